// File: source/ooo_cfg.svh
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// Register counts
`define OOO_ARCH_REGS 32
`define OOO_PHYS_REGS 64

// Reorder buffer depth
`define OOO_ROB_DEPTH 16

// Field widths
`define OOO_DATA_W 32
`define OOO_IMM_W 16
`define OOO_ARCH_W 5
`define OOO_PHYS_W 6
`define OOO_ROB_W 4

`define OOO_MUL_LAT 3

`endif

// File: source/ooo_pkg.sv
`default_nettype none

`include "ooo_cfg.svh"

package ooo_pkg;

    typedef logic [`OOO_ARCH_W-1:0] arch_reg_t;
    typedef logic [`OOO_PHYS_W-1:0] phys_reg_t;
    typedef logic [`OOO_ROB_W-1:0]  rob_tag_t;
    typedef logic [`OOO_DATA_W-1:0] word_t;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_XOR = 3'd2,
        OP_LI  = 3'd3,
        OP_MUL = 3'd4
    } op_e;

    typedef struct packed {
        op_e                   op;
        arch_reg_t             rd;
        arch_reg_t             rs1;
        arch_reg_t             rs2;
        logic [`OOO_IMM_W-1:0] imm;
    } instr_t;

    typedef struct packed {
        arch_reg_t rd;
        word_t     data;
    } retire_t;

    // Old mapping is freed when the entry retires
    typedef struct packed {
        arch_reg_t rd;
        phys_reg_t new_phys;
        phys_reg_t old_phys;
    } rob_entry_t;

    typedef struct packed {
        op_e       op;
        phys_reg_t dst;
        rob_tag_t  tag;
        word_t     a;
        word_t     b;
        word_t     imm;
    } exec_req_t;

    typedef struct packed {
        logic      valid;
        phys_reg_t phys;
        rob_tag_t  tag;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire

// File: source/rename_table.sv
`timescale 1ns/100ps
`default_nettype none

`include "ooo_cfg.svh"

module rename_table (
    input  logic                       clk,
    input  logic                       rst,
    input  ooo_pkg::arch_reg_t         rs1,
    input  ooo_pkg::arch_reg_t         rs2,
    output ooo_pkg::phys_reg_t [1:0]   src_phys,
    input  logic                       rename_we,
    input  ooo_pkg::arch_reg_t         rd,
    input  ooo_pkg::phys_reg_t         rd_new,
    output ooo_pkg::phys_reg_t         rd_old,
    input  logic                       commit_we,
    input  ooo_pkg::arch_reg_t         commit_rd,
    input  ooo_pkg::phys_reg_t         commit_phys
);

    ooo_pkg::phys_reg_t spec_map [`OOO_ARCH_REGS];
    ooo_pkg::phys_reg_t commit_map [`OOO_ARCH_REGS];

    assign src_phys[0] = spec_map[rs1];
    assign src_phys[1] = spec_map[rs2];
    assign rd_old      = spec_map[rd];

    // Speculative mapping, written at dispatch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
                spec_map[i] <= ooo_pkg::phys_reg_t'(i);
            end
        end else if (rename_we) begin
            spec_map[rd] <= rd_new;
        end
    end

    // Architectural mapping, written in program order at retire
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
                commit_map[i] <= ooo_pkg::phys_reg_t'(i);
            end
        end else if (commit_we) begin
            commit_map[commit_rd] <= commit_phys;
        end
    end

endmodule

`default_nettype wire

// File: source/free_list.sv
`timescale 1ns/100ps
`default_nettype none

`include "ooo_cfg.svh"

module free_list (
    input  logic               clk,
    input  logic               rst,
    input  logic               pop,
    input  logic               push,
    input  ooo_pkg::phys_reg_t push_phys,
    output ooo_pkg::phys_reg_t head_phys,
    output logic               empty
);

    localparam int DEPTH = `OOO_PHYS_REGS - `OOO_ARCH_REGS;
    localparam int PTR_W = $clog2(DEPTH);

    ooo_pkg::phys_reg_t queue [DEPTH];
    logic [PTR_W-1:0]   head;
    logic [PTR_W-1:0]   tail;
    logic [PTR_W:0]     count;

    assign head_phys = queue[head];
    assign empty     = (count == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Everything above the architectural range starts free
            for (int i = 0; i < DEPTH; i++) begin
                queue[i] <= ooo_pkg::phys_reg_t'(`OOO_ARCH_REGS + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= (PTR_W + 1)'(DEPTH);
        end else begin
            if (push) begin
                queue[tail] <= push_phys;
                tail        <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/reorder_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "ooo_cfg.svh"

module reorder_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  ooo_pkg::rob_entry_t push_entry,
    output ooo_pkg::rob_tag_t   tail,
    output logic                full,
    input  ooo_pkg::wb_t        wb,
    input  logic                pop,
    output ooo_pkg::rob_entry_t head_entry,
    output logic                head_done
);

    localparam int CNT_W = $clog2(`OOO_ROB_DEPTH) + 1;

    ooo_pkg::rob_entry_t      entries [`OOO_ROB_DEPTH];
    logic [`OOO_ROB_DEPTH-1:0] done;
    ooo_pkg::rob_tag_t        head;
    logic [CNT_W-1:0]         count;

    assign full       = (count == CNT_W'(`OOO_ROB_DEPTH));
    assign head_entry = entries[head];
    assign head_done  = (count != '0) && done[head];

    always_ff @(posedge clk) begin
        if (push) begin
            entries[tail] <= push_entry;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // Completion from the single writeback port
            if (wb.valid) begin
                done[wb.tag] <= 1'b1;
            end
            if (push) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/phys_regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "ooo_cfg.svh"

module phys_regfile (
    input  logic                     clk,
    input  logic                     rst,
    input  ooo_pkg::phys_reg_t [1:0] rd_addr,
    output ooo_pkg::word_t [1:0]     rd_data,
    output logic [1:0]               busy,
    input  ooo_pkg::phys_reg_t       ret_addr,
    output ooo_pkg::word_t           ret_data,
    input  logic                     busy_set,
    input  ooo_pkg::phys_reg_t       busy_phys,
    input  ooo_pkg::wb_t             wb
);

    ooo_pkg::word_t           regs [`OOO_PHYS_REGS];
    logic [`OOO_PHYS_REGS-1:0] busy_bits;

    // Operand ports for the issue slot
    assign rd_data[0] = regs[rd_addr[0]];
    assign rd_data[1] = regs[rd_addr[1]];
    assign busy[0]    = busy_bits[rd_addr[0]];
    assign busy[1]    = busy_bits[rd_addr[1]];

    assign ret_data = regs[ret_addr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `OOO_PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.phys] <= wb.data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_bits <= '0;
        end else begin
            if (wb.valid) begin
                busy_bits[wb.phys] <= 1'b0;
            end
            // A freshly allocated register is never the one being written back
            if (busy_set) begin
                busy_bits[busy_phys] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "ooo_cfg.svh"

module exec_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  ooo_pkg::exec_req_t      req,
    input  logic                    req_valid,
    output ooo_pkg::wb_t            wb,
    output logic [`OOO_MUL_LAT-1:0] mul_busy
);

    ooo_pkg::wb_t   alu_q;
    ooo_pkg::wb_t   mul_q [`OOO_MUL_LAT];
    ooo_pkg::word_t mul_b;
    ooo_pkg::word_t alu_res;

    always_comb begin
        case (req.op)
            ooo_pkg::OP_SUB: alu_res = req.a - req.b;
            ooo_pkg::OP_XOR: alu_res = req.a ^ req.b;
            ooo_pkg::OP_LI:  alu_res = req.imm;
            default:         alu_res = req.a + req.b;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alu_q <= '0;
        end else begin
            alu_q.valid <= req_valid && (req.op != ooo_pkg::OP_MUL);
            alu_q.phys  <= req.dst;
            alu_q.tag   <= req.tag;
            alu_q.data  <= alu_res;
        end
    end

    // Stage 0 holds the operands, stage 1 multiplies, later stages only delay
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `OOO_MUL_LAT; i++) begin
                mul_q[i] <= '0;
            end
        end else begin
            mul_q[0].valid <= req_valid && (req.op == ooo_pkg::OP_MUL);
            mul_q[0].phys  <= req.dst;
            mul_q[0].tag   <= req.tag;
            mul_q[0].data  <= req.a;
            mul_q[1]       <= mul_q[0];
            mul_q[1].data  <= mul_q[0].data * mul_b;
            for (int i = 2; i < `OOO_MUL_LAT; i++) begin
                mul_q[i] <= mul_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        mul_b <= req.b;
    end

    // Issue never lets both paths finish in the same cycle
    assign wb = mul_q[`OOO_MUL_LAT-1].valid ? mul_q[`OOO_MUL_LAT-1] : alu_q;

    always_comb begin
        for (int i = 0; i < `OOO_MUL_LAT; i++) begin
            mul_busy[i] = mul_q[i].valid;
        end
    end

endmodule

`default_nettype wire

// File: source/core_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "ooo_cfg.svh"

module core_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  ooo_pkg::instr_t          in_instr,
    output logic                     out_valid,
    input  logic                     out_ready,
    input  logic                     fl_empty,
    input  logic                     rob_full,
    input  logic                     head_done,
    input  ooo_pkg::phys_reg_t [1:0] src_phys,
    input  logic [1:0]               src_busy,
    input  ooo_pkg::phys_reg_t       dst_phys,
    input  ooo_pkg::rob_tag_t        rob_tail,
    input  ooo_pkg::word_t [1:0]     src_data,
    input  logic [`OOO_MUL_LAT-1:0]  mul_busy,
    output logic                     rename_we,
    output logic                     fl_pop,
    output logic                     rob_push,
    output logic                     rob_pop,
    output logic                     busy_set,
    output ooo_pkg::phys_reg_t [1:0] slot_src,
    output ooo_pkg::exec_req_t       issue,
    output logic                     issue_valid
);

    logic                  run;
    logic                  slot_valid;
    ooo_pkg::op_e          slot_op;
    ooo_pkg::phys_reg_t    slot_dst;
    ooo_pkg::rob_tag_t     slot_tag;
    logic [`OOO_IMM_W-1:0] slot_imm;
    logic                  srcs_ready;
    logic                  wb_clash;
    logic                  accept;

    // li reads no source registers
    assign srcs_ready  = (slot_op == ooo_pkg::OP_LI) || (src_busy == 2'b00);
    // One-cycle result would land on the mul writeback
    assign wb_clash    = (slot_op != ooo_pkg::OP_MUL) && mul_busy[`OOO_MUL_LAT-2];
    assign issue_valid = slot_valid && srcs_ready && !wb_clash;

    assign in_ready = run && !fl_empty && !rob_full && (!slot_valid || issue_valid);
    assign accept   = in_valid && in_ready;

    assign rename_we = accept;
    assign fl_pop    = accept;
    assign rob_push  = accept;
    assign busy_set  = accept;

    assign out_valid = head_done;
    assign rob_pop   = head_done && out_ready;

    always_comb begin
        issue.op  = slot_op;
        issue.dst = slot_dst;
        issue.tag = slot_tag;
        issue.a   = src_data[0];
        issue.b   = src_data[1];
        issue.imm = {{(`OOO_DATA_W-`OOO_IMM_W){slot_imm[`OOO_IMM_W-1]}}, slot_imm};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run        <= 1'b0;
            slot_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (accept) begin
                slot_valid <= 1'b1;
            end else if (issue_valid) begin
                slot_valid <= 1'b0;
            end
        end
    end

    // Renamed instruction waits here until its sources are written
    always_ff @(posedge clk) begin
        if (accept) begin
            slot_op  <= in_instr.op;
            slot_dst <= dst_phys;
            slot_tag <= rob_tail;
            slot_src <= src_phys;
            slot_imm <= in_instr.imm;
        end
    end

endmodule

`default_nettype wire

// File: source/ooo_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "ooo_cfg.svh"

module ooo_core (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  ooo_pkg::instr_t  in_instr,
    output logic             out_valid,
    input  logic             out_ready,
    output ooo_pkg::retire_t out_retire
);

    ooo_pkg::phys_reg_t [1:0] src_phys;
    ooo_pkg::phys_reg_t [1:0] slot_src;
    ooo_pkg::word_t [1:0]     src_data;
    logic [1:0]               src_busy;
    ooo_pkg::phys_reg_t       dst_phys;
    ooo_pkg::phys_reg_t       rd_old;
    ooo_pkg::rob_tag_t        rob_tail;
    ooo_pkg::rob_entry_t      push_entry;
    ooo_pkg::rob_entry_t      head_entry;
    ooo_pkg::word_t           ret_data;
    ooo_pkg::exec_req_t       issue;
    ooo_pkg::wb_t             wb;
    logic [`OOO_MUL_LAT-1:0]  mul_busy;
    logic                     fl_empty;
    logic                     rob_full;
    logic                     head_done;
    logic                     rename_we;
    logic                     fl_pop;
    logic                     rob_push;
    logic                     rob_pop;
    logic                     busy_set;
    logic                     issue_valid;

    assign push_entry.rd       = in_instr.rd;
    assign push_entry.new_phys = dst_phys;
    assign push_entry.old_phys = rd_old;

    assign out_retire.rd   = head_entry.rd;
    assign out_retire.data = ret_data;

    core_ctrl i_core_ctrl (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_instr    (in_instr),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .fl_empty    (fl_empty),
        .rob_full    (rob_full),
        .head_done   (head_done),
        .src_phys    (src_phys),
        .src_busy    (src_busy),
        .dst_phys    (dst_phys),
        .rob_tail    (rob_tail),
        .src_data    (src_data),
        .mul_busy    (mul_busy),
        .rename_we   (rename_we),
        .fl_pop      (fl_pop),
        .rob_push    (rob_push),
        .rob_pop     (rob_pop),
        .busy_set    (busy_set),
        .slot_src    (slot_src),
        .issue       (issue),
        .issue_valid (issue_valid)
    );

    rename_table i_rename_table (
        .clk         (clk),
        .rst         (rst),
        .rs1         (in_instr.rs1),
        .rs2         (in_instr.rs2),
        .src_phys    (src_phys),
        .rename_we   (rename_we),
        .rd          (in_instr.rd),
        .rd_new      (dst_phys),
        .rd_old      (rd_old),
        .commit_we   (rob_pop),
        .commit_rd   (head_entry.rd),
        .commit_phys (head_entry.new_phys)
    );

    // Retire hands the previous mapping back
    free_list i_free_list (
        .clk       (clk),
        .rst       (rst),
        .pop       (fl_pop),
        .push      (rob_pop),
        .push_phys (head_entry.old_phys),
        .head_phys (dst_phys),
        .empty     (fl_empty)
    );

    reorder_buffer i_reorder_buffer (
        .clk        (clk),
        .rst        (rst),
        .push       (rob_push),
        .push_entry (push_entry),
        .tail       (rob_tail),
        .full       (rob_full),
        .wb         (wb),
        .pop        (rob_pop),
        .head_entry (head_entry),
        .head_done  (head_done)
    );

    phys_regfile i_phys_regfile (
        .clk       (clk),
        .rst       (rst),
        .rd_addr   (slot_src),
        .rd_data   (src_data),
        .busy      (src_busy),
        .ret_addr  (head_entry.new_phys),
        .ret_data  (ret_data),
        .busy_set  (busy_set),
        .busy_phys (dst_phys),
        .wb        (wb)
    );

    exec_unit i_exec_unit (
        .clk       (clk),
        .rst       (rst),
        .req       (issue),
        .req_valid (issue_valid),
        .wb        (wb),
        .mul_busy  (mul_busy)
    );

endmodule

`default_nettype wire

// File: test/ooo_core_chk.sv
`timescale 1ns/100ps
`default_nettype none

module ooo_core_chk (
    input logic             clk,
    input logic             rst,
    input logic             in_valid,
    input logic             in_ready,
    input ooo_pkg::instr_t  in_instr,
    input logic             out_valid,
    input logic             out_ready,
    input ooo_pkg::retire_t out_retire
);

    logic assert_failed = 1'b0;

    // Retire payload holds until the sink takes it
    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_retire))
        else begin
            assert_failed = 1'b1;
            $error("out_valid or out_retire changed before the transfer");
        end

    in_hold: assert property (@(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable(in_instr))
        else begin
            assert_failed = 1'b1;
            $error("in_valid or in_instr changed before the transfer");
        end

    quiet_in_reset: assert property (@(posedge clk) rst |-> !out_valid && !in_ready)
        else begin
            assert_failed = 1'b1;
            $error("Handshake output high during reset");
        end

    quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !out_valid)
        else begin
            assert_failed = 1'b1;
            $error("out_valid high in the first cycle after reset");
        end

endmodule

bind ooo_core ooo_core_chk i_ooo_core_chk (.*);

`default_nettype wire

// File: test/ooo_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ooo_core_tb;

    localparam int          NUM_VEC      = 40;
    localparam int          VEC_COLS     = 7;
    localparam int          HALF_PERIOD  = 10;
    localparam int          RESET_CYCLES = 10;
    localparam int          DRIVE_DELAY  = 1;
    localparam int          WAIT_LIMIT   = 300;
    localparam int          READY_LIMIT  = 20;
    localparam int          START_STALL  = 60;
    localparam int          DRAIN_CYCLES = 20;
    localparam logic [31:0] SEED         = 32'hd03a_9440;

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic             in_ready;
    ooo_pkg::instr_t  in_instr;
    logic             out_valid;
    logic             out_ready;
    ooo_pkg::retire_t out_retire;

    // Seven words per vector in the order op rd rs1 rs2 imm exp_rd exp_data
    logic [31:0] vec_mem [NUM_VEC*VEC_COLS];
    logic [31:0] drv_state;
    logic [31:0] mon_state;
    logic        saw_stall;

    ooo_core i_ooo_core (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_instr   (in_instr),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_retire (out_retire)
    );

    always #HALF_PERIOD clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic ooo_pkg::instr_t vec_instr(input int n);
        ooo_pkg::instr_t ins;
        int              base;
        base    = n * VEC_COLS;
        ins.op  = ooo_pkg::op_e'(vec_mem[base][2:0]);
        ins.rd  = vec_mem[base+1][4:0];
        ins.rs1 = vec_mem[base+2][4:0];
        ins.rs2 = vec_mem[base+3][4:0];
        ins.imm = vec_mem[base+4][15:0];
        return ins;
    endfunction

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    // Holds the instruction until the DUT takes it
    task automatic send_instr(input ooo_pkg::instr_t ins);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_instr = ins;
        @(negedge clk);
        while (!in_ready) begin
            saw_stall = 1'b1;
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout: in_ready stayed low for %0d cycles", WAIT_LIMIT);
                abort_run();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic drive_vectors();
        int gap;
        for (int n = 0; n < NUM_VEC; n++) begin
            send_instr(vec_instr(n));
            drv_state = lcg_next(drv_state);
            gap       = drv_state[31:30];
            if (gap > 0) begin
                in_valid = 1'b0;
                repeat (gap) @(posedge clk);
                #DRIVE_DELAY;
            end
        end
        in_valid = 1'b0;
    endtask

    // Long stall first so the reorder buffer fills, random stalls after
    task automatic collect_retires();
        int idx;
        int idle;
        int stall_left;
        int base;
        idx        = 0;
        idle       = 0;
        stall_left = START_STALL;
        while (idx < NUM_VEC) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (stall_left > 0) begin
                out_ready = 1'b0;
                stall_left--;
            end else begin
                mon_state = lcg_next(mon_state);
                out_ready = (mon_state[31:29] != 3'd0);
                if (!out_ready) begin
                    stall_left = 4 + mon_state[27:24];
                end
            end
            @(negedge clk);
            if (out_valid && out_ready) begin
                base = idx * VEC_COLS;
                check_value($sformatf("retire %0d rd", idx), vec_mem[base+5],
                            32'(out_retire.rd));
                check_value($sformatf("retire %0d data", idx), vec_mem[base+6],
                            out_retire.data);
                idx++;
                idle = 0;
            end else begin
                idle++;
                if (idle > WAIT_LIMIT) begin
                    $display("Timeout: retire %0d did not arrive within %0d cycles",
                             idx, WAIT_LIMIT);
                    abort_run();
                end
            end
        end
    endtask

    always @(negedge clk) begin
        assert (!i_ooo_core.i_ooo_core_chk.assert_failed) else begin
            $display("A handshake assertion in the bound checker failed");
            abort_run();
        end
    end

    initial begin
        int waited;
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_instr  = '0;
        out_ready = 1'b0;
        drv_state = SEED;
        mon_state = lcg_next(SEED);
        saw_stall = 1'b0;
        $readmemh("test/ooo_vectors.txt", vec_mem);

        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clk);
            assert (!out_valid && !in_ready) else begin
                $display("A handshake output was high during reset");
                abort_run();
            end
        end
        @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        waited = 0;
        @(negedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > READY_LIMIT) begin
                $display("Timeout: in_ready did not rise after reset");
                abort_run();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;

        fork
            drive_vectors();
            collect_retires();
        join

        // Nothing may retire beyond the last vector
        @(posedge clk);
        #DRIVE_DELAY;
        out_ready = 1'b1;
        for (int c = 0; c < DRAIN_CYCLES; c++) begin
            @(negedge clk);
            assert (!out_valid) else begin
                $display("An extra retire appeared after the last vector");
                abort_run();
            end
        end

        if (saw_stall) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("in_ready never fell while an instruction was waiting");
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: test/ooo_vectors.txt
// op rd rs1 rs2 imm exp_rd exp_data (hex)
// op: 0 add, 1 sub, 2 xor, 3 li, 4 mul
3 01 00 00 0005 01 00000005
3 02 00 00 0003 02 00000003
0 03 01 02 0000 03 00000008
1 04 01 02 0000 04 00000002
2 05 01 02 0000 05 00000006
3 06 00 00 fffe 06 fffffffe
0 07 06 01 0000 07 00000003
1 08 02 01 0000 08 fffffffe
0 01 01 01 0000 01 0000000a
0 01 01 01 0000 01 00000014
1 01 01 02 0000 01 00000011
3 09 00 00 1234 09 00001234
4 0a 09 09 0000 0a 014b5a90
3 0b 00 00 0007 0b 00000007
0 0c 02 02 0000 0c 00000006
2 0d 01 02 0000 0d 00000012
0 0e 0a 0b 0000 0e 014b5a97
4 0f 0e 02 0000 0f 03e20fc5
4 10 02 02 0000 10 00000009
3 11 00 00 8000 11 ffff8000
4 12 11 06 0000 12 00010000
1 13 00 01 0000 13 ffffffef
2 14 13 06 0000 14 00000011
0 00 00 02 0000 00 00000003
0 15 00 00 0000 15 00000006
3 16 00 00 7fff 16 00007fff
4 17 16 16 0000 17 3fff0001
0 17 17 17 0000 17 7ffe0002
3 18 00 00 0100 18 00000100
4 19 18 18 0000 19 00010000
4 19 19 19 0000 19 00000000
2 1a 19 09 0000 1a 00001234
1 1b 1a 0b 0000 1b 0000122d
0 1c 1b 1b 0000 1c 0000245a
4 1d 1c 11 0000 1d edd30000
3 1e 00 00 0001 1e 00000001
0 1f 1e 1e 0000 1f 00000002
1 1f 1f 1e 0000 1f 00000001
2 05 05 1f 0000 05 00000007
0 01 1d 05 0000 01 edd30007

// File: flist.f
+incdir+source
source/ooo_pkg.sv
source/rename_table.sv
source/free_list.sv
source/reorder_buffer.sv
source/phys_regfile.sv
source/exec_unit.sv
source/core_ctrl.sv
source/ooo_core.sv
test/ooo_core_chk.sv
test/ooo_core_tb.sv

// File: Bender.yml
package:
  name: ooo_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/ooo_pkg.sv
      - source/rename_table.sv
      - source/free_list.sv
      - source/reorder_buffer.sv
      - source/phys_regfile.sv
      - source/exec_unit.sv
      - source/core_ctrl.sv
      - source/ooo_core.sv
  - target: test
    files:
      - test/ooo_core_chk.sv
      - test/ooo_core_tb.sv
